// ==== hdl/dpu_defs.svh ====
`ifndef DPU_DEFS_SVH
`define DPU_DEFS_SVH

// Datapath widths
`define DPU_DATA_W 32
`define DPU_LANES 4
`define DPU_LANE_W 8
`define DPU_TAG_W 5
`define DPU_OP_W 4

// MAC unit walks one lane per cycle
`define DPU_MAC_LAT `DPU_LANES

// Register map
`define DPU_CSR_AW 2
`define DPU_CSR_ENABLE 2'd0
`define DPU_CSR_STATUS 2'd1
`define DPU_CSR_ID 2'd2

// Read-only instance identifier
`define DPU_ID 32'hD9B0_0001

`endif

// ==== hdl/dpu_pkg.sv ====
`include "dpu_defs.svh"

package dpu_pkg;

    // ==============================
    // Opcodes
    // ==============================

    // Upper bits roughly pick the unit
    // Codes not listed here are illegal
    typedef enum logic [`DPU_OP_W-1:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_MUL   = 4'd2,
        OP_VADDS = 4'd4,
        OP_VMAX  = 4'd5,
        OP_DOT   = 4'd8,
        OP_ACLR  = 4'd9,
        OP_RELU  = 4'd10
    } dpu_op_e;

    // ==============================
    // Data word
    // ==============================

    // Signed int8 lane
    typedef logic signed [`DPU_LANE_W-1:0] dpu_lane_t;

    // Same 32 bits seen as one integer or as four lanes
    // Lane 0 sits in bits 7:0
    typedef union packed {
        logic [`DPU_DATA_W-1:0]        scalar;
        dpu_lane_t [`DPU_LANES-1:0]    lanes;
    } dpu_word_u;

    // ==============================
    // Transactions
    // ==============================

    // CPU request
    typedef struct packed {
        dpu_op_e                opcode;
        dpu_word_u              operand_a;
        dpu_word_u              operand_b;
        logic [`DPU_TAG_W-1:0]  tag;
    } dpu_req_t;

    // Response back to the CPU
    // Tag echoes the request so the core knows the destination register
    typedef struct packed {
        dpu_word_u              data;
        logic                   error;
        logic [`DPU_TAG_W-1:0]  tag;
    } dpu_rsp_t;

    // Run-time unit enables
    // Bit 0 alu, bit 1 simd, bit 2 mac
    typedef struct packed {
        logic mac_en;
        logic simd_en;
        logic alu_en;
    } dpu_cfg_t;

endpackage

// ==== hdl/dpu_csr.sv ====
`timescale 1ns/1ps
`include "dpu_defs.svh"

module dpu_csr (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      cfg_we_i,
    input  logic [`DPU_CSR_AW-1:0]    cfg_addr_i,
    input  logic [`DPU_DATA_W-1:0]    cfg_wdata_i,
    output logic [`DPU_DATA_W-1:0]    cfg_rdata_o,
    input  logic                      err_pulse_i,
    output dpu_pkg::dpu_cfg_t         cfg_o,
    output logic                      error_o
);

    localparam int CFG_W = $bits(dpu_pkg::dpu_cfg_t);

    dpu_pkg::dpu_cfg_t  cfg_q;
    logic               err_sticky_q;
    logic [7:0]         err_cnt_q;
    logic               status_clr;

    // Write-1-to-clear on status bit 0
    assign status_clr = cfg_we_i && (cfg_addr_i == `DPU_CSR_STATUS) && cfg_wdata_i[0];

    // Enable mask
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // All units on out of reset
            cfg_q <= '1;
        end else if (cfg_we_i && (cfg_addr_i == `DPU_CSR_ENABLE)) begin
            cfg_q <= dpu_pkg::dpu_cfg_t'(cfg_wdata_i[CFG_W-1:0]);
        end
    end

    // Sticky flag and saturating error count
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_sticky_q <= 1'b0;
            err_cnt_q    <= '0;
        end else if (status_clr) begin
            err_sticky_q <= 1'b0;
            err_cnt_q    <= '0;
        end else if (err_pulse_i) begin
            err_sticky_q <= 1'b1;
            // Stops at 255
            if (err_cnt_q != 8'hFF) begin
                err_cnt_q <= err_cnt_q + 8'd1;
            end
        end
    end

    // Combinational readback
    always_comb begin
        case (cfg_addr_i)
            `DPU_CSR_ENABLE: cfg_rdata_o = {{(`DPU_DATA_W-CFG_W){1'b0}}, cfg_q};
            `DPU_CSR_STATUS: cfg_rdata_o = {16'h0, err_cnt_q, 7'h0, err_sticky_q};
            `DPU_CSR_ID:     cfg_rdata_o = `DPU_ID;
            default:         cfg_rdata_o = '0;
        endcase
    end

    assign cfg_o   = cfg_q;
    assign error_o = err_sticky_q;

endmodule

// ==== hdl/dpu_dispatch.sv ====
`timescale 1ns/1ps

module dpu_dispatch (
    input  logic                clk_i,
    input  logic                arst_n_i,
    // CPU request side
    input  logic                req_valid_i,
    input  dpu_pkg::dpu_req_t   req_i,
    output logic                req_ready_o,
    // CPU response side
    output logic                rsp_valid_o,
    output dpu_pkg::dpu_rsp_t   rsp_o,
    input  logic                rsp_ready_i,
    // Register block
    input  dpu_pkg::dpu_cfg_t   cfg_i,
    output logic                busy_o,
    output logic                err_pulse_o,
    // Units
    output logic                alu_start_o,
    output logic                simd_start_o,
    output logic                mac_start_o,
    output dpu_pkg::dpu_req_t   unit_req_o,
    input  logic                alu_done_i,
    input  dpu_pkg::dpu_rsp_t   alu_rsp_i,
    input  logic                simd_done_i,
    input  dpu_pkg::dpu_rsp_t   simd_rsp_i,
    input  logic                mac_done_i,
    input  dpu_pkg::dpu_rsp_t   mac_rsp_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_HOLD
    } state_e;

    state_e             state_q;
    // One-hot unit select, bit order mac, simd, alu
    logic [2:0]         unit_hit;
    logic [2:0]         unit_en;
    logic [2:0]         sel_q;
    logic [2:0]         start_q;
    logic               accept;
    logic               done_hit;
    dpu_pkg::dpu_req_t  unit_req_q;
    dpu_pkg::dpu_rsp_t  done_rsp;
    dpu_pkg::dpu_rsp_t  rsp_q;

    // ==============================
    // Decode and enable check
    // ==============================

    always_comb begin
        unit_hit = 3'b000;
        case (req_i.opcode)
            dpu_pkg::OP_ADD, dpu_pkg::OP_SUB, dpu_pkg::OP_MUL: unit_hit = 3'b001;
            dpu_pkg::OP_VADDS, dpu_pkg::OP_VMAX:               unit_hit = 3'b010;
            dpu_pkg::OP_DOT, dpu_pkg::OP_ACLR, dpu_pkg::OP_RELU: unit_hit = 3'b100;
            default:                                           unit_hit = 3'b000;
        endcase
    end

    // Disabled unit looks the same as an illegal opcode
    assign unit_en = unit_hit & {cfg_i.mac_en, cfg_i.simd_en, cfg_i.alu_en};

    // Single transaction in flight
    assign req_ready_o = (state_q == ST_IDLE);
    assign busy_o      = ~req_ready_o;
    assign accept      = req_valid_i && req_ready_o;

    // Done from the unit that was started
    assign done_hit = |(sel_q & {mac_done_i, simd_done_i, alu_done_i});

    always_comb begin
        done_rsp = alu_rsp_i;
        if (sel_q[1]) begin
            done_rsp = simd_rsp_i;
        end
        if (sel_q[2]) begin
            done_rsp = mac_rsp_i;
        end
    end

    // ==============================
    // Transaction FSM
    // ==============================

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
            sel_q   <= '0;
            start_q <= '0;
        end else begin
            // Start is a single-cycle strobe
            start_q <= '0;
            case (state_q)
                ST_IDLE: begin
                    if (req_valid_i) begin
                        sel_q <= unit_en;
                        if (|unit_en) begin
                            start_q <= unit_en;
                            state_q <= ST_RUN;
                        end else begin
                            // Error response goes out next cycle
                            state_q <= ST_HOLD;
                        end
                    end
                end
                ST_RUN: begin
                    if (done_hit) begin
                        state_q <= ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    // Hold until the CPU takes the response
                    if (rsp_ready_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            unit_req_q <= req_i;
        end
        if (accept && !(|unit_en)) begin
            rsp_q.data  <= '0;
            rsp_q.error <= 1'b1;
            rsp_q.tag   <= req_i.tag;
        end else if ((state_q == ST_RUN) && done_hit) begin
            rsp_q <= done_rsp;
        end
    end

    assign rsp_valid_o  = (state_q == ST_HOLD);
    assign rsp_o        = rsp_q;
    assign err_pulse_o  = rsp_valid_o && rsp_ready_i && rsp_q.error;

    assign alu_start_o  = start_q[0];
    assign simd_start_o = start_q[1];
    assign mac_start_o  = start_q[2];
    assign unit_req_o   = unit_req_q;

endmodule

// ==== hdl/dpu_alu_unit.sv ====
`timescale 1ns/1ps
`include "dpu_defs.svh"

module dpu_alu_unit (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                start_i,
    input  dpu_pkg::dpu_req_t   req_i,
    output logic                done_o,
    output dpu_pkg::dpu_rsp_t   rsp_o
);

    logic [`DPU_DATA_W-1:0] result;
    logic                   bad_op;

    // Scalar views only, results wrap modulo 2^32
    always_comb begin
        bad_op = 1'b0;
        case (req_i.opcode)
            dpu_pkg::OP_ADD: result = req_i.operand_a.scalar + req_i.operand_b.scalar;
            dpu_pkg::OP_SUB: result = req_i.operand_a.scalar - req_i.operand_b.scalar;
            // Low word of the product
            dpu_pkg::OP_MUL: result = req_i.operand_a.scalar * req_i.operand_b.scalar;
            default: begin
                result = '0;
                bad_op = 1'b1;
            end
        endcase
    end

    // Done one cycle after start
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            done_o <= 1'b0;
        end else begin
            done_o <= start_i;
        end
    end

    // Result register
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            rsp_o.data.scalar <= result;
            rsp_o.error       <= bad_op;
            rsp_o.tag         <= req_i.tag;
        end
    end

endmodule

// ==== hdl/dpu_simd_unit.sv ====
`timescale 1ns/1ps
`include "dpu_defs.svh"

module dpu_simd_unit (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                start_i,
    input  dpu_pkg::dpu_req_t   req_i,
    output logic                done_o,
    output dpu_pkg::dpu_rsp_t   rsp_o
);

    dpu_pkg::dpu_word_u result;
    logic               bad_op;

    // Lanes never carry into each other
    always_comb begin : p_lanes
        logic signed [`DPU_LANE_W:0] sum;
        result = '0;
        bad_op = 1'b0;
        for (int i = 0; i < `DPU_LANES; i++) begin
            // One extra bit catches the overflow
            sum = (`DPU_LANE_W+1)'(req_i.operand_a.lanes[i])
                + (`DPU_LANE_W+1)'(req_i.operand_b.lanes[i]);
            case (req_i.opcode)
                dpu_pkg::OP_VADDS: begin
                    // Clamp to -128..127
                    if (sum > 9'sd127) begin
                        result.lanes[i] = 8'h7F;
                    end else if (sum < -9'sd128) begin
                        result.lanes[i] = 8'h80;
                    end else begin
                        result.lanes[i] = sum[`DPU_LANE_W-1:0];
                    end
                end
                dpu_pkg::OP_VMAX: begin
                    // Signed compare per lane
                    result.lanes[i] = (req_i.operand_a.lanes[i] > req_i.operand_b.lanes[i]) ?
                                      req_i.operand_a.lanes[i] : req_i.operand_b.lanes[i];
                end
                default: bad_op = 1'b1;
            endcase
        end
    end

    // Single-cycle latency
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            done_o <= 1'b0;
        end else begin
            done_o <= start_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            rsp_o.data  <= result;
            rsp_o.error <= bad_op;
            rsp_o.tag   <= req_i.tag;
        end
    end

endmodule

// ==== hdl/dpu_mac_unit.sv ====
`timescale 1ns/1ps
`include "dpu_defs.svh"

module dpu_mac_unit (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                start_i,
    input  dpu_pkg::dpu_req_t   req_i,
    output logic                done_o,
    output dpu_pkg::dpu_rsp_t   rsp_o
);

    localparam int CNT_W = $clog2(`DPU_MAC_LAT);

    logic                            active_q;
    logic [CNT_W-1:0]                cnt_q;
    logic [CNT_W-1:0]                lane_idx;
    logic                            step;
    logic                            last;
    dpu_pkg::dpu_req_t               req_q;
    dpu_pkg::dpu_req_t               cur_req;
    logic signed [2*`DPU_LANE_W-1:0] prod;
    logic signed [`DPU_DATA_W-1:0]   acc_q;
    logic signed [`DPU_DATA_W-1:0]   acc_nxt;
    logic signed [`DPU_DATA_W-1:0]   result;
    logic                            bad_op;

    // ==============================
    // Lane sequencing
    // ==============================

    // Lane 0 is handled in the start cycle itself
    assign step     = start_i || active_q;
    assign cur_req  = start_i ? req_i : req_q;
    assign lane_idx = start_i ? '0 : cnt_q;
    assign last     = step && (lane_idx == CNT_W'(`DPU_MAC_LAT-1));

    // int8 x int8 fits in 16 bits
    assign prod = cur_req.operand_a.lanes[lane_idx] * cur_req.operand_b.lanes[lane_idx];

    always_comb begin
        acc_nxt = acc_q;
        result  = acc_q;
        bad_op  = 1'b0;
        case (cur_req.opcode)
            // Accumulator wraps on overflow
            dpu_pkg::OP_DOT: begin
                acc_nxt = acc_q + `DPU_DATA_W'(prod);
                result  = acc_nxt;
            end
            dpu_pkg::OP_ACLR: begin
                acc_nxt = '0;
                result  = '0;
            end
            // ReLU readout, accumulator untouched
            dpu_pkg::OP_RELU: result = acc_q[`DPU_DATA_W-1] ? '0 : acc_q;
            default:          bad_op = 1'b1;
        endcase
    end

    // ==============================
    // State
    // ==============================

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
            acc_q    <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o   <= last;
            active_q <= start_i || (active_q && !last);
            if (step) begin
                cnt_q <= CNT_W'(lane_idx + 1'b1);
                acc_q <= acc_nxt;
            end
        end
    end

    // Operands held for the remaining lanes
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            req_q <= req_i;
        end
        if (last) begin
            rsp_o.data.scalar <= result;
            rsp_o.error       <= bad_op;
            rsp_o.tag         <= cur_req.tag;
        end
    end

endmodule

// ==== hdl/dpu_subsystem.sv ====
`timescale 1ns/1ps
`include "dpu_defs.svh"

module dpu_subsystem (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    // Request port
    input  logic                      req_valid_i,
    input  dpu_pkg::dpu_req_t         req_i,
    output logic                      req_ready_o,
    // Response port
    output logic                      rsp_valid_o,
    output dpu_pkg::dpu_rsp_t         rsp_o,
    input  logic                      rsp_ready_i,
    // Configuration port
    input  logic                      cfg_we_i,
    input  logic [`DPU_CSR_AW-1:0]    cfg_addr_i,
    input  logic [`DPU_DATA_W-1:0]    cfg_wdata_i,
    output logic [`DPU_DATA_W-1:0]    cfg_rdata_o,
    // Status
    output logic                      busy_o,
    output logic                      error_o
);

    dpu_pkg::dpu_cfg_t  cfg;
    logic               err_pulse;
    dpu_pkg::dpu_req_t  unit_req;
    logic               alu_start;
    logic               simd_start;
    logic               mac_start;
    logic               alu_done;
    logic               simd_done;
    logic               mac_done;
    dpu_pkg::dpu_rsp_t  alu_rsp;
    dpu_pkg::dpu_rsp_t  simd_rsp;
    dpu_pkg::dpu_rsp_t  mac_rsp;

    // ==============================
    // Control
    // ==============================

    dpu_csr i_dpu_csr (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .err_pulse_i (err_pulse),
        .cfg_o       (cfg),
        .error_o     (error_o)
    );

    dpu_dispatch i_dpu_dispatch (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_ready_o  (req_ready_o),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_o        (rsp_o),
        .rsp_ready_i  (rsp_ready_i),
        .cfg_i        (cfg),
        .busy_o       (busy_o),
        .err_pulse_o  (err_pulse),
        .alu_start_o  (alu_start),
        .simd_start_o (simd_start),
        .mac_start_o  (mac_start),
        .unit_req_o   (unit_req),
        .alu_done_i   (alu_done),
        .alu_rsp_i    (alu_rsp),
        .simd_done_i  (simd_done),
        .simd_rsp_i   (simd_rsp),
        .mac_done_i   (mac_done),
        .mac_rsp_i    (mac_rsp)
    );

    // ==============================
    // Accelerators
    // ==============================

    // All three share the request bus from the dispatcher
    dpu_alu_unit i_dpu_alu_unit (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .start_i  (alu_start),
        .req_i    (unit_req),
        .done_o   (alu_done),
        .rsp_o    (alu_rsp)
    );

    dpu_simd_unit i_dpu_simd_unit (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .start_i  (simd_start),
        .req_i    (unit_req),
        .done_o   (simd_done),
        .rsp_o    (simd_rsp)
    );

    dpu_mac_unit i_dpu_mac_unit (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .start_i  (mac_start),
        .req_i    (unit_req),
        .done_o   (mac_done),
        .rsp_o    (mac_rsp)
    );

endmodule

// ==== verification/dpu_subsystem_sva.sv ====
`timescale 1ns/1ps

module dpu_subsystem_sva (
    input logic                clk_i,
    input logic                arst_n_i,
    input logic                req_ready_o,
    input logic                rsp_valid_o,
    input dpu_pkg::dpu_rsp_t   rsp_o,
    input logic                rsp_ready_i,
    input logic                busy_o
);

    // ==============================
    // Response channel
    // ==============================

    // Stalled response keeps its payload and stays valid
    a_rsp_stable: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o))
    ) else $error("rsp_o changed while waiting for rsp_ready_i");

    // No new request while a response is pending
    a_no_accept_on_rsp: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        rsp_valid_o |-> !req_ready_o
    ) else $error("req_ready_o high while rsp_valid_o is high");

    // ==============================
    // Status
    // ==============================

    a_busy_inverse: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        busy_o == !req_ready_o
    ) else $error("busy_o is not the inverse of req_ready_o");

endmodule

// ==== verification/dpu_subsystem_tb.sv ====
`timescale 1ns/1ps
`include "dpu_defs.svh"

module dpu_subsystem_tb;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 1;
    // Columns per data line: kind, opcode, a, b, tag, expected data, expected error
    localparam int FIELDS     = 7;
    localparam int MAX_LINES  = 64;

    // Command kinds in the data file
    localparam int CMD_END    = 0;
    localparam int CMD_REQ    = 1;
    localparam int CMD_WRITE  = 2;
    localparam int CMD_READ   = 3;

    logic                      clk;
    logic                      arst_n;
    logic                      req_valid;
    dpu_pkg::dpu_req_t         req;
    logic                      req_ready;
    logic                      rsp_valid;
    dpu_pkg::dpu_rsp_t         rsp;
    logic                      rsp_ready;
    logic                      cfg_we;
    logic [`DPU_CSR_AW-1:0]    cfg_addr;
    logic [`DPU_DATA_W-1:0]    cfg_wdata;
    logic [`DPU_DATA_W-1:0]    cfg_rdata;
    logic                      busy;
    logic                      error;

    logic [31:0]               vec_mem [0:MAX_LINES*FIELDS-1];
    int                        num_lines;
    bit                        vectors_loaded;

    dpu_subsystem i_dpu_subsystem (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .req_valid_i (req_valid),
        .req_i       (req),
        .req_ready_o (req_ready),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp),
        .rsp_ready_i (rsp_ready),
        .cfg_we_i    (cfg_we),
        .cfg_addr_i  (cfg_addr),
        .cfg_wdata_i (cfg_wdata),
        .cfg_rdata_o (cfg_rdata),
        .busy_o      (busy),
        .error_o     (error)
    );

    // Handshake rules checked inside the DUT scope
    bind dpu_subsystem dpu_subsystem_sva i_dpu_subsystem_sva (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .rsp_ready_i (rsp_ready_i),
        .busy_o      (busy_o)
    );

    // ==============================
    // Clock and watchdog
    // ==============================

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD/2);
            clk = ~clk;
        end
    end

    // Budget of 20 cycles per data line plus reset margin
    initial begin : watchdog
        wait (vectors_loaded);
        #((num_lines * 20 + 50) * CLK_PERIOD);
        $display("Timeout: tests did not finish within %0d clock periods", num_lines * 20 + 50);
        abort_run();
    end

    // ==============================
    // Helpers
    // ==============================

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            abort_run();
        end
    endtask

    // Inputs change just after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic do_request(input logic [31:0] op, input logic [31:0] a,
                              input logic [31:0] b, input logic [31:0] tag,
                              input logic [31:0] exp_data, input logic [31:0] exp_err);
        int hold_cycles;
        next_cycle();
        req.opcode           = dpu_pkg::dpu_op_e'(op[`DPU_OP_W-1:0]);
        req.operand_a.scalar = a;
        req.operand_b.scalar = b;
        req.tag              = tag[`DPU_TAG_W-1:0];
        req_valid            = 1'b1;
        // Accepted on the edge after ready is seen
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        next_cycle();
        req_valid = 1'b0;
        // Valid is looked at just after the edge that raises it
        while (!rsp_valid) begin
            next_cycle();
        end
        // Random back-pressure of 0 to 3 cycles before taking the response
        hold_cycles = $urandom % 4;
        repeat (hold_cycles) begin
            next_cycle();
        end
        rsp_ready = 1'b1;
        @(negedge clk);
        check_value("rsp_valid_o", 32'(rsp_valid), 32'd1);
        check_value("rsp_o.data", rsp.data.scalar, exp_data);
        check_value("rsp_o.error", 32'(rsp.error), exp_err);
        check_value("rsp_o.tag", 32'(rsp.tag), tag);
        next_cycle();
        rsp_ready = 1'b0;
        // Exactly one response per request
        @(negedge clk);
        check_value("rsp_valid_o", 32'(rsp_valid), 32'd0);
        check_value("req_ready_o", 32'(req_ready), 32'd1);
    endtask

    task automatic cfg_write(input logic [31:0] addr, input logic [31:0] data);
        next_cycle();
        cfg_we    = 1'b1;
        cfg_addr  = addr[`DPU_CSR_AW-1:0];
        cfg_wdata = data;
        next_cycle();
        cfg_we    = 1'b0;
    endtask

    // Readback is combinational, sampled mid-cycle
    task automatic cfg_read_check(input logic [31:0] addr, input logic [31:0] exp_data,
                                  input logic [31:0] exp_err);
        next_cycle();
        cfg_addr = addr[`DPU_CSR_AW-1:0];
        @(negedge clk);
        check_value("cfg_rdata_o", cfg_rdata, exp_data);
        check_value("error_o", 32'(error), exp_err);
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin : main
        int base;
        void'($urandom(69));
        arst_n      = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        rsp_ready   = 1'b0;
        cfg_we      = 1'b0;
        cfg_addr    = '0;
        cfg_wdata   = '0;
        for (int i = 0; i < MAX_LINES * FIELDS; i++) begin
            vec_mem[i] = '0;
        end
        $readmemh("verification/dpu_tests.mem", vec_mem);
        // Data lines run up to the end marker
        num_lines = 0;
        while (num_lines < MAX_LINES && vec_mem[num_lines*FIELDS] != CMD_END) begin
            num_lines++;
        end
        if (num_lines == 0) begin
            $display("No test vectors were found in the data file");
            abort_run();
        end
        vectors_loaded = 1'b1;

        repeat (4) begin
            @(posedge clk);
        end
        #DRIVE_DLY;
        arst_n = 1'b1;

        // Reset state, enable mask reads all ones
        @(negedge clk);
        check_value("req_ready_o", 32'(req_ready), 32'd1);
        check_value("rsp_valid_o", 32'(rsp_valid), 32'd0);
        check_value("busy_o", 32'(busy), 32'd0);
        check_value("error_o", 32'(error), 32'd0);
        check_value("cfg_rdata_o", cfg_rdata, 32'h0000_0007);

        for (int line = 0; line < num_lines; line++) begin
            base = line * FIELDS;
            case (vec_mem[base])
                CMD_REQ: do_request(vec_mem[base+1], vec_mem[base+2], vec_mem[base+3],
                                    vec_mem[base+4], vec_mem[base+5], vec_mem[base+6]);
                CMD_WRITE: cfg_write(vec_mem[base+2], vec_mem[base+3]);
                CMD_READ: cfg_read_check(vec_mem[base+2], vec_mem[base+5], vec_mem[base+6]);
                default: begin
                    $display("Unknown command kind %0d on data line %0d", vec_mem[base], line);
                    abort_run();
                end
            endcase
        end

        next_cycle();
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== verification/dpu_tests.mem ====
// kind op operand_a operand_b tag exp_data exp_err (all hex)
// kind 1 request, 2 config write (a addr, b data), 3 config read (exp_err is error_o), 0 end
1 0 7FFFFFFF 00000001 01 80000000 0
1 0 FFFFFFFF 00000002 02 00000001 0
1 1 00000000 00000001 03 FFFFFFFF 0
1 2 00010000 00010003 04 00030000 0
1 2 FFFFFFFF 00000005 05 FFFFFFFB 0
1 4 7F8010F0 01FF20F0 06 7F8030E0 0
1 5 807F05FB 7F80FB05 07 7F7F0505 0
1 4 00FF00FF 00010001 08 00000000 0
1 9 12345678 9ABCDEF0 09 00000000 0
1 8 04030201 01020304 0A 00000014 0
1 8 8080F60A 7F010AF6 0B FFFFBF4C 0
1 A 00000000 00000000 0C 00000000 0
1 8 7F7F7F7F 7F7F7F7F 0D 0000BB50 0
1 A 00000000 00000000 0E 0000BB50 0
2 0 00000000 00000003 00 00000000 0
3 0 00000000 00000000 00 00000003 0
1 8 01010101 01010101 0F 00000000 1
1 0 00000005 00000006 10 0000000B 0
3 0 00000001 00000000 00 00000101 1
1 3 00000001 00000001 11 00000000 1
1 7 00000001 00000001 12 00000000 1
1 C 00000001 00000001 13 00000000 1
3 0 00000001 00000000 00 00000401 1
2 0 00000001 00000001 00 00000000 0
3 0 00000001 00000000 00 00000000 0
3 0 00000002 00000000 00 D9B00001 0
2 0 00000000 00000007 00 00000000 0
1 A 00000000 00000000 14 0000BB50 0
1 5 00000000 FFFFFFFF 15 00000000 0
0 0 00000000 00000000 00 00000000 0

// ==== files.f ====
+incdir+hdl
hdl/dpu_pkg.sv
hdl/dpu_csr.sv
hdl/dpu_dispatch.sv
hdl/dpu_alu_unit.sv
hdl/dpu_simd_unit.sv
hdl/dpu_mac_unit.sv
hdl/dpu_subsystem.sv
verification/dpu_subsystem_sva.sv
verification/dpu_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the DPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module dpu_subsystem_tb -f files.f -o dpu_sim

sim_out=$(./obj_dir/dpu_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
